/* hdl/memPkg.sv */
// Geometry must be powers of two, addresses are physical, and MemWait must be at least 2
package memPkg;

  // Datapath and address widths
  localparam int WordBits     = 32;
  localparam int AddrBits     = 32;
  localparam int ByteLanes    = WordBits / 8;
  localparam int ByteBits     = $clog2(ByteLanes);
  localparam int WordAddrBits = AddrBits - ByteBits;

  // Cache geometry, same for both caches
  localparam int BlockWords = 4;
  localparam int CacheLines = 16;
  localparam int OffsetBits = $clog2(BlockWords);
  localparam int IndexBits  = $clog2(CacheLines);
  localparam int TagBits    = WordAddrBits - OffsetBits - IndexBits;

  // Bus memory depth and latency
  localparam int MemWords    = 1024;
  localparam int MemAddrBits = $clog2(MemWords);
  localparam int MemWait     = 2;
  localparam int WaitBits    = $clog2(MemWait + 1);

  // Cache controller states
  typedef enum logic [1:0] {
    cacheIdle,
    cacheFill,
    cacheSingle
  } cacheStateT;

  // One word transfer on the shared bus
  typedef struct packed {
    logic [WordAddrBits-1:0] addr;
    logic                    write;
    logic [ByteLanes-1:0]    mask;
    logic [WordBits-1:0]     wData;
  } busReqT;

  typedef struct packed {
    logic                valid;
    logic [AddrBits-1:0] addr;
  } fetchReqT;

  // mask is only looked at for stores
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrBits-1:0]  addr;
    logic [ByteLanes-1:0] mask;
    logic [WordBits-1:0]  wData;
  } dataReqT;

endpackage

/* hdl/instrCache.sv */
// Fetch must stay stable while stall is high; lines are never written by stores, use invalidate
module instrCache (
  input  logic                        clk,
  input  logic                        rstN,
  input  memPkg::fetchReqT            fetch,
  input  logic                        enable,
  input  logic                        invalidate,
  input  logic                        hReady,
  input  logic [memPkg::WordBits-1:0] hRData,
  output logic [memPkg::WordBits-1:0] instr,
  output logic                        stall,
  output logic                        hRequest,
  output memPkg::busReqT              busReq
);
  import memPkg::*;

  logic [TagBits-1:0]    tagArr  [CacheLines];
  logic [WordBits-1:0]   dataArr [CacheLines][BlockWords];
  logic [CacheLines-1:0] validArr;

  cacheStateT              state;
  logic [OffsetBits-1:0]   fillCount;
  logic [WordAddrBits-1:0] wordAddr;
  logic [TagBits-1:0]      tag;
  logic [IndexBits-1:0]    index;
  logic [OffsetBits-1:0]   offset;
  logic                    hit;
  logic                    lastBeat;

  assign wordAddr = fetch.addr[AddrBits-1:ByteBits];
  assign {tag, index, offset} = wordAddr;

  // Disabled cache never hits
  assign hit      = enable && validArr[index] && (tagArr[index] == tag);
  assign lastBeat = hReady && (fillCount == OffsetBits'(BlockWords - 1));

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= cacheIdle;
      fillCount <= '0;
      validArr  <= '0;
    end
    else
    begin
      case (state)
        cacheIdle:
          if (fetch.valid && !hit)
          begin
            state     <= enable ? cacheFill : cacheSingle;
            fillCount <= '0;
          end
        cacheFill:
          if (hReady)
          begin
            fillCount <= fillCount + 1'b1;
            if (lastBeat)
              state <= cacheIdle;
          end
        default:
          if (hReady)
            state <= cacheIdle;
      endcase
      // Line turns valid only after its last word
      if (invalidate)
        validArr <= '0;
      else if (state == cacheFill && lastBeat)
        validArr[index] <= 1'b1;
    end
  end

  // Line words arrive in address order
  always_ff @(posedge clk)
  begin
    if (state == cacheFill && hReady)
    begin
      dataArr[index][fillCount] <= hRData;
      if (lastBeat)
        tagArr[index] <= tag;
    end
  end

  always_comb
  begin
    hRequest     = (state != cacheIdle);
    busReq.addr  = (state == cacheFill) ? {tag, index, fillCount} : wordAddr;
    busReq.write = 1'b0;
    busReq.mask  = '1;
    busReq.wData = '0;
  end

  // Uncached word comes straight off the bus in its ready cycle
  assign instr = (state == cacheSingle) ? hRData : dataArr[index][offset];

  always_comb
  begin
    case (state)
      cacheIdle: stall = fetch.valid && !hit;
      cacheFill: stall = 1'b1;
      default:   stall = !hReady;
    endcase
  end

endmodule

/* hdl/dataCache.sv */
// Write-through, no allocate on store; stores made while disabled leave resident lines untouched
module dataCache (
  input  logic                        clk,
  input  logic                        rstN,
  input  memPkg::dataReqT             access,
  input  logic                        enable,
  input  logic                        invalidate,
  input  logic                        hReady,
  input  logic [memPkg::WordBits-1:0] hRData,
  output logic [memPkg::WordBits-1:0] readData,
  output logic                        stall,
  output logic                        hRequest,
  output memPkg::busReqT              busReq
);
  import memPkg::*;

  logic [TagBits-1:0]    tagArr  [CacheLines];
  logic [WordBits-1:0]   dataArr [CacheLines][BlockWords];
  logic [CacheLines-1:0] validArr;

  cacheStateT              state;
  logic [OffsetBits-1:0]   fillCount;
  logic [WordAddrBits-1:0] wordAddr;
  logic [TagBits-1:0]      tag;
  logic [IndexBits-1:0]    index;
  logic [OffsetBits-1:0]   offset;
  logic                    hit;
  logic                    lastBeat;
  logic                    storing;
  logic                    needBus;

  assign wordAddr = access.addr[AddrBits-1:ByteBits];
  assign {tag, index, offset} = wordAddr;

  assign hit      = enable && validArr[index] && (tagArr[index] == tag);
  assign lastBeat = hReady && (fillCount == OffsetBits'(BlockWords - 1));
  assign storing  = (state == cacheSingle) && access.write;

  // Every store goes to the bus, loads only on a miss
  assign needBus = access.valid && (access.write || !hit);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= cacheIdle;
      fillCount <= '0;
      validArr  <= '0;
    end
    else
    begin
      case (state)
        cacheIdle:
          if (needBus)
          begin
            state     <= (enable && !access.write) ? cacheFill : cacheSingle;
            fillCount <= '0;
          end
        cacheFill:
          if (hReady)
          begin
            fillCount <= fillCount + 1'b1;
            if (lastBeat)
              state <= cacheIdle;
          end
        default:
          if (hReady)
            state <= cacheIdle;
      endcase
      if (invalidate)
        validArr <= '0;
      else if (state == cacheFill && lastBeat)
        validArr[index] <= 1'b1;
    end
  end

  // Fill words, or merge store bytes into a resident line
  always_ff @(posedge clk)
  begin
    if (state == cacheFill && hReady)
    begin
      dataArr[index][fillCount] <= hRData;
      if (lastBeat)
        tagArr[index] <= tag;
    end
    else if (storing && hReady && hit)
    begin
      for (int b = 0; b < ByteLanes; b++)
      begin
        if (access.mask[b])
          dataArr[index][offset][8*b +: 8] <= access.wData[8*b +: 8];
      end
    end
  end

  always_comb
  begin
    hRequest     = (state != cacheIdle);
    busReq.addr  = (state == cacheFill) ? {tag, index, fillCount} : wordAddr;
    busReq.write = storing;
    busReq.mask  = storing ? access.mask : '1;
    busReq.wData = access.wData;
  end

  // Single-word loads return bus data in the ready cycle
  assign readData = (state == cacheSingle) ? hRData : dataArr[index][offset];

  always_comb
  begin
    case (state)
      cacheIdle: stall = needBus;
      cacheFill: stall = 1'b1;
      default:   stall = !hReady;
    endcase
  end

endmodule

/* hdl/busArbiter.sv */
// Data cache wins ties; an owner keeps the bus until its ready pulse, one beat per grant
module busArbiter (
  input  logic           clk,
  input  logic           rstN,
  input  logic           hRequestF,
  input  memPkg::busReqT busReqF,
  input  logic           hRequestM,
  input  memPkg::busReqT busReqM,
  input  logic           hReady,
  output logic           hReadyF,
  output logic           hReadyM,
  output logic           hRequest,
  output memPkg::busReqT busReq
);

  typedef enum logic [1:0] {
    grantIdle,
    grantData,
    grantFetch
  } grantT;

  grantT state;
  logic  pickData;
  logic  pickFetch;

  // Choice in idle is combinational so the memory sees the request the same cycle
  assign pickData  = (state == grantData) || (state == grantIdle && hRequestM);
  assign pickFetch = (state == grantFetch) || (state == grantIdle && !hRequestM);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      state <= grantIdle;
    else
    begin
      case (state)
        grantIdle:
          if (hRequestM)
            state <= grantData;
          else if (hRequestF)
            state <= grantFetch;
        default:
          if (hReady)
            state <= grantIdle;
      endcase
    end
  end

  assign hRequest = (pickData && hRequestM) || (pickFetch && hRequestF);
  assign busReq   = pickData ? busReqM : busReqF;

  // Ready goes back only to the owner
  assign hReadyM = hReady && (state == grantData);
  assign hReadyF = hReady && (state == grantFetch);

endmodule

/* hdl/busMemory.sv */
// Address wraps at MemWords words; unwritten words read as undefined, MemWait must be 2 or more
module busMemory (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        hRequest,
  input  memPkg::busReqT              busReq,
  output logic                        hReady,
  output logic [memPkg::WordBits-1:0] hRData
);
  import memPkg::*;

  logic [WordBits-1:0]    mem [MemWords];
  logic                   busy;
  logic [WaitBits-1:0]    waitCount;
  logic                   finish;
  logic [MemAddrBits-1:0] wordIdx;

  assign wordIdx = busReq.addr[MemAddrBits-1:0];

  // Last wait cycle, ready rises at the following edge
  assign finish = busy && (waitCount == WaitBits'(MemWait - 1));

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      busy      <= 1'b0;
      waitCount <= '0;
      hReady    <= 1'b0;
    end
    else
    begin
      hReady <= finish;
      if (finish)
        busy <= 1'b0;
      else if (busy)
        waitCount <= waitCount + 1'b1;
      else if (hRequest && !hReady)
      begin
        // Request still held in the ready cycle is the old one, so skip it
        busy      <= 1'b1;
        waitCount <= WaitBits'(1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (finish)
    begin
      if (busReq.write)
      begin
        for (int b = 0; b < ByteLanes; b++)
        begin
          if (busReq.mask[b])
            mem[wordIdx][8*b +: 8] <= busReq.wData[8*b +: 8];
        end
      end
      else
        hRData <= mem[wordIdx];
    end
  end

endmodule

/* hdl/memSystem.sv */
// Stall outputs mark the end of a variable latency; requests must be held while stalled
module memSystem (
  input  logic                        clk,
  input  logic                        rstN,
  input  memPkg::fetchReqT            fetch,
  input  logic                        iEnable,
  input  logic                        iInvalidate,
  input  memPkg::dataReqT             access,
  input  logic                        dEnable,
  input  logic                        dInvalidate,
  output logic [memPkg::WordBits-1:0] instr,
  output logic                        iStall,
  output logic [memPkg::WordBits-1:0] readData,
  output logic                        dStall
);
  import memPkg::*;

  logic                hRequestF, hRequestM, hRequest;
  logic                hReadyF, hReadyM, hReady;
  busReqT              busReqF, busReqM, busReq;
  logic [WordBits-1:0] hRData;

  // I$
  instrCache iCache (
    .clk       (clk        ),
    .rstN      (rstN       ),
    .fetch     (fetch      ),
    .enable    (iEnable    ),
    .invalidate(iInvalidate),
    .hReady    (hReadyF    ),
    .hRData    (hRData     ),
    .instr     (instr      ),
    .stall     (iStall     ),
    .hRequest  (hRequestF  ),
    .busReq    (busReqF    )
  );

  // D$
  dataCache dCache (
    .clk       (clk        ),
    .rstN      (rstN       ),
    .access    (access     ),
    .enable    (dEnable    ),
    .invalidate(dInvalidate),
    .hReady    (hReadyM    ),
    .hRData    (hRData     ),
    .readData  (readData   ),
    .stall     (dStall     ),
    .hRequest  (hRequestM  ),
    .busReq    (busReqM    )
  );

  busArbiter arbiter (.*);

  // Read data is shared by both caches
  busMemory memory (.*);

endmodule

/* test/memSystem_assert.sv */
// Bound to each requester side of busArbiter and to busMemory; checks one request/ready bus
module memSystem_assert (
  input logic           clk,
  input logic           rstN,
  input logic           hRequest,
  input memPkg::busReqT busReq,
  input logic           hReady
);

  // Waiting request must hold still
  property holdWhileWaiting;
    @(posedge clk) disable iff (!rstN)
      (hRequest && !hReady) |=> (hRequest && $stable(busReq));
  endproperty

  property singleReady;
    @(posedge clk) disable iff (!rstN)
      hReady |=> !hReady;
  endproperty

  property readyNeedsRequest;
    @(posedge clk) disable iff (!rstN)
      hReady |-> hRequest;
  endproperty

  stableReq: assert property (holdWhileWaiting)
    else $error("bus request changed while waiting for ready");
  readyPulse: assert property (singleReady)
    else $error("hReady high two cycles in a row");
  readyOwner: assert property (readyNeedsRequest)
    else $error("hReady without a pending request");

endmodule

// Data cache side of the arbiter
bind busArbiter memSystem_assert dataChk (
  .clk(clk), .rstN(rstN), .hRequest(hRequestM), .busReq(busReqM), .hReady(hReadyM)
);

// Instruction cache side of the arbiter
bind busArbiter memSystem_assert fetchChk (
  .clk(clk), .rstN(rstN), .hRequest(hRequestF), .busReq(busReqF), .hReady(hReadyF)
);

bind busMemory memSystem_assert memChk (
  .clk(clk), .rstN(rstN), .hRequest(hRequest), .busReq(busReq), .hReady(hReady)
);

/* test/memSystem_tb.sv */
// Tests only the first TestWords words of memory, all written before any load or fetch reads them
module memSystem_tb;
  import memPkg::*;

  localparam int TestWords  = 128;
  localparam int RandOps    = 200;
  localparam int Pairs      = 8;
  localparam int StaleLines = 8;
  localparam int InvLoads   = 32;
  // Upper bound on operations over all phases
  localparam int NumOps    = TestWords + 2 * RandOps + 4 * BlockWords + 8 + 2 * Pairs
                             + 3 * StaleLines + InvLoads;
  localparam longint Limit = longint'(NumOps) * (BlockWords + 1) * (MemWait + 2) * 20 + 2000;

  logic                clk;
  logic                rstN;
  fetchReqT            fetch;
  logic                iEnable;
  logic                iInvalidate;
  dataReqT             access;
  logic                dEnable;
  logic                dInvalidate;
  logic [WordBits-1:0] instr;
  logic                iStall;
  logic [WordBits-1:0] readData;
  logic                dStall;

  // Reference model state
  logic [WordBits-1:0] modelMem [MemWords];
  logic [WordBits-1:0] iLine    [CacheLines][BlockWords];
  logic [WordBits-1:0] dLine    [CacheLines][BlockWords];
  int                  iTag     [CacheLines];
  int                  dTag     [CacheLines];
  bit                  iValid   [CacheLines];
  bit                  dValid   [CacheLines];
  bit                  iEn;
  bit                  dEn;
  logic [WordBits-1:0] expInstr;
  logic [WordBits-1:0] expData;

  memSystem dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    #(Limit);
    $display("simulation timed out, stall never released");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  task automatic reportFail(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  task automatic checkInstr(input logic [WordBits-1:0] got, input logic [WordBits-1:0] exp,
                            input fetchReqT req);
    if (got !== exp)
      reportFail($sformatf("fetch addr %h gave %h, expected %h", req.addr, got, exp));
  endtask

  task automatic checkData(input logic [WordBits-1:0] got, input logic [WordBits-1:0] exp,
                           input dataReqT req);
    if (got !== exp)
      reportFail($sformatf("load addr %h gave %h, expected %h", req.addr, got, exp));
  endtask

  task automatic checkStall(input logic got, input logic exp, input string port);
    if (got !== exp)
      reportFail($sformatf("%s was %b in first cycle, expected %b", port, got, exp));
  endtask

  // Expected result of one access; also advances the model
  function automatic logic [WordBits-1:0] predict(input bit isFetch, input dataReqT r);
    int word;
    int off;
    int idx;
    int tg;
    int m;
    logic [WordBits-1:0] res;
    word = int'(r.addr >> ByteBits);
    off  = word % BlockWords;
    idx  = (word / BlockWords) % CacheLines;
    tg   = word / (BlockWords * CacheLines);
    m    = word % MemWords;
    res  = 'x;
    if (isFetch)
    begin
      if (!iEn)
        res = modelMem[m];
      else
      begin
        if (!(iValid[idx] && iTag[idx] == tg))
        begin
          for (int w = 0; w < BlockWords; w++)
            iLine[idx][w] = modelMem[m - off + w];
          iValid[idx] = 1'b1;
          iTag[idx]   = tg;
        end
        res = iLine[idx][off];
      end
    end
    else if (r.write)
    begin
      for (int b = 0; b < ByteLanes; b++)
      begin
        if (r.mask[b])
        begin
          modelMem[m][8*b +: 8] = r.wData[8*b +: 8];
          if (dEn && dValid[idx] && dTag[idx] == tg)
            dLine[idx][off][8*b +: 8] = r.wData[8*b +: 8];
        end
      end
    end
    else if (!dEn)
      res = modelMem[m];
    else
    begin
      if (!(dValid[idx] && dTag[idx] == tg))
      begin
        for (int w = 0; w < BlockWords; w++)
          dLine[idx][w] = modelMem[m - off + w];
        dValid[idx] = 1'b1;
        dTag[idx]   = tg;
      end
      res = dLine[idx][off];
    end
    return res;
  endfunction

  task automatic doAccess(input dataReqT req, input bit checkFirst, input bit firstStall);
    logic [WordBits-1:0] e;
    e = predict(1'b0, req);
    @(posedge clk);
    expData = e;
    access <= req;
    @(negedge clk);
    if (checkFirst)
      checkStall(dStall, firstStall, "dStall");
    while (dStall)
      @(negedge clk);
    @(posedge clk);
    access <= '0;
  endtask

  task automatic doFetch(input logic [AddrBits-1:0] addr, input bit checkFirst,
                         input bit firstStall);
    fetchReqT f;
    dataReqT  r;
    logic [WordBits-1:0] e;
    f.valid = 1'b1;
    f.addr  = addr;
    r       = '0;
    r.addr  = addr;
    e = predict(1'b1, r);
    @(posedge clk);
    expInstr = e;
    fetch <= f;
    @(negedge clk);
    if (checkFirst)
      checkStall(iStall, firstStall, "iStall");
    while (iStall)
      @(negedge clk);
    @(posedge clk);
    fetch <= '0;
  endtask

  function automatic dataReqT makeReq(input bit write, input int word,
                                      input logic [ByteLanes-1:0] mask,
                                      input logic [WordBits-1:0] wData);
    dataReqT r;
    r.valid = 1'b1;
    r.write = write;
    r.addr  = AddrBits'(word) << ByteBits;
    r.mask  = mask;
    r.wData = wData;
    return r;
  endfunction

  task automatic setEnables(input bit i, input bit d);
    @(posedge clk);
    iEnable <= i;
    dEnable <= d;
    iEn = i;
    dEn = d;
  endtask

  task automatic pulseInvalidate(input bit inst, input bit data);
    @(posedge clk);
    iInvalidate <= inst;
    dInvalidate <= data;
    @(posedge clk);
    iInvalidate <= 1'b0;
    dInvalidate <= 1'b0;
    for (int l = 0; l < CacheLines; l++)
    begin
      if (inst)
        iValid[l] = 1'b0;
      if (data)
        dValid[l] = 1'b0;
    end
  endtask

  task automatic randomOp(input bit withFetch);
    int kind;
    int word;
    kind = $urandom % (withFetch ? 3 : 2);
    word = $urandom % TestWords;
    if (kind == 0)
      doAccess(makeReq(1'b1, word, ByteLanes'($urandom), $urandom), 1'b0, 1'b0);
    else if (kind == 1)
      doAccess(makeReq(1'b0, word, '0, '0), 1'b0, 1'b0);
    else
      doFetch(AddrBits'(word) << ByteBits, 1'b0, 1'b0);
  endtask

  // Compare each result in the cycle its stall is low
  always @(negedge clk)
  begin
    if (rstN)
    begin
      if (fetch.valid && !iStall)
        checkInstr(instr, expInstr, fetch);
      if (access.valid && !access.write && !dStall)
        checkData(readData, expData, access);
    end
  end

  initial
  begin
    int base;
    int word;
    int stale [StaleLines];
    void'($urandom(4317));
    rstN        = 1'b0;
    fetch       = '0;
    access      = '0;
    iEnable     = 1'b1;
    dEnable     = 1'b1;
    iInvalidate = 1'b0;
    dInvalidate = 1'b0;
    iEn         = 1'b1;
    dEn         = 1'b1;
    for (int l = 0; l < CacheLines; l++)
    begin
      iValid[l] = 1'b0;
      dValid[l] = 1'b0;
    end
    repeat (10) @(posedge clk);
    rstN <= 1'b1;

    // Define every tested word first
    for (int w = 0; w < TestWords; w++)
      doAccess(makeReq(1'b1, w, '1, $urandom), 1'b0, 1'b0);

    // Random masked stores and loads
    for (int n = 0; n < RandOps; n++)
      randomOp(1'b0);

    // First load of a line stalls, the rest hit
    pulseInvalidate(1'b0, 1'b1);
    // Consecutive lines never share an index
    base = $urandom % (TestWords / BlockWords);
    for (int l = 0; l < 4; l++)
    begin
      word = ((base + l) % (TestWords / BlockWords)) * BlockWords;
      for (int w = 0; w < BlockWords; w++)
        doAccess(makeReq(1'b0, word + w, '0, '0), 1'b1, w == 0);
    end

    // Instruction cache keeps old word until invalidated
    word = $urandom % TestWords;
    pulseInvalidate(1'b1, 1'b0);
    doAccess(makeReq(1'b1, word, '1, $urandom), 1'b0, 1'b0);
    doFetch(AddrBits'(word) << ByteBits, 1'b1, 1'b1);
    doAccess(makeReq(1'b1, word, '1, $urandom), 1'b0, 1'b0);
    doFetch(AddrBits'(word) << ByteBits, 1'b1, 1'b0);
    pulseInvalidate(1'b1, 1'b0);
    doFetch(AddrBits'(word) << ByteBits, 1'b1, 1'b1);

    // Both caches bypassed, so every read stalls
    setEnables(1'b0, 1'b0);
    for (int n = 0; n < RandOps; n++)
      randomOp(1'b1);
    word = $urandom % TestWords;
    doAccess(makeReq(1'b0, word, '0, '0), 1'b1, 1'b1);
    doAccess(makeReq(1'b0, word, '0, '0), 1'b1, 1'b1);
    setEnables(1'b1, 1'b1);

    // Fetch and load misses at once
    for (int p = 0; p < Pairs; p++)
    begin
      pulseInvalidate(1'b1, 1'b1);
      fork
        doFetch(AddrBits'($urandom % TestWords) << ByteBits, 1'b1, 1'b1);
        doAccess(makeReq(1'b0, $urandom % TestWords, '0, '0), 1'b1, 1'b1);
      join
    end

    // Resident lines made stale by bypassed stores
    for (int n = 0; n < StaleLines; n++)
    begin
      stale[n] = n * BlockWords + $urandom % BlockWords;
      doAccess(makeReq(1'b0, stale[n], '0, '0), 1'b0, 1'b0);
      setEnables(1'b1, 1'b0);
      doAccess(makeReq(1'b1, stale[n], '1, $urandom), 1'b0, 1'b0);
      setEnables(1'b1, 1'b1);
    end

    // Stale lines from bypassed stores are dropped
    pulseInvalidate(1'b0, 1'b1);
    for (int n = 0; n < StaleLines; n++)
      doAccess(makeReq(1'b0, stale[n], '0, '0), 1'b1, 1'b1);
    for (int n = 0; n < InvLoads; n++)
      doAccess(makeReq(1'b0, $urandom % TestWords, '0, '0), 1'b0, 1'b0);

    repeat (2) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

/* all.f */
hdl/memPkg.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/busArbiter.sv
hdl/busMemory.sv
hdl/memSystem.sv
test/memSystem_assert.sv
test/memSystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module memSystem_tb -f all.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/VmemSystem_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
